// File: design/egress_pkg.sv
/* Shared bus widths, port counts and beat types for the MPLS egress stage */

package egress_pkg;

    //////////////////////////////////////////////////////////////////////
    // Egress bus

    // Bytes carried by one 64-bit input beat
    localparam int BEAT_BYTES = 8;

    typedef logic [BEAT_BYTES*8-1:0] beat_t;
    typedef logic [BEAT_BYTES-1:0]   keep_t;

    //////////////////////////////////////////////////////////////////////
    // Physical ports

    // Narrow (8-bit) ports come first, the wide (32-bit) ports follow
    localparam int NUM_NARROW_PORTS = 2;
    localparam int NUM_WIDE_PORTS   = 2;
    localparam int NUM_PORTS        = NUM_NARROW_PORTS + NUM_WIDE_PORTS;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    //////////////////////////////////////////////////////////////////////
    // Packet and buffer sizing

    localparam int MAX_PACKET_BYTES = 64;
    localparam int MAX_PACKET_BEATS = MAX_PACKET_BYTES / BEAT_BYTES;

    // Room for four maximum-size packets per port
    localparam int BUFFER_BEATS = 4 * MAX_PACKET_BEATS;

endpackage

// File: design/egress_port_decode.sv
/* Input stage: registers egress beats and steers each packet
   to one buffer by a one-hot select held for the whole packet */

`timescale 1ns/1ns

module egress_port_decode
    import egress_pkg::*;
#(
    parameter int PORTS = NUM_PORTS
) (
    input  logic             clk_ifc,
    input  logic             rst,
    input  logic             in_valid,
    input  beat_t            in_data,
    input  keep_t            in_keep,
    input  logic             in_last,
    input  port_idx_t        in_port,
    output logic             wr_valid,
    output beat_t            wr_data,
    output keep_t            wr_keep,
    output logic             wr_last,
    output logic [PORTS-1:0] wr_sel
);

    // High between the first and the last beat of a packet
    logic      in_pkt;
    port_idx_t dest_q;
    port_idx_t dest;

    // The port field only counts on the first beat
    assign dest = in_pkt ? dest_q : in_port;

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            in_pkt   <= 1'b0;
            dest_q   <= '0;
            wr_valid <= 1'b0;
            wr_last  <= 1'b0;
            wr_sel   <= '0;
        end else begin
            wr_valid <= in_valid;
            wr_last  <= in_valid & in_last;
            if (in_valid) begin
                in_pkt <= ~in_last;
                if (!in_pkt) begin
                    dest_q <= in_port;
                end
                wr_sel <= PORTS'(1) << dest;
            end
        end
    end

    // Beat payload, one cycle behind the input
    always_ff @(posedge clk_ifc) begin
        wr_data <= in_data;
        wr_keep <= in_keep;
    end

endmodule

// File: design/egress_packet_buffer.sv
/* Per-port circular beat store that commits whole packets
   and drops a packet that runs out of room, with an overflow strobe */

`timescale 1ns/1ns

module egress_packet_buffer
    import egress_pkg::*;
#(
    parameter int DEPTH = BUFFER_BEATS
) (
    input  logic  clk_ifc,
    input  logic  rst,
    input  logic  wr_valid,
    input  logic  wr_sel_this,
    input  beat_t wr_data,
    input  keep_t wr_keep,
    input  logic  wr_last,
    input  logic  rd_req,
    output logic  pkt_avail,
    output beat_t rd_data,
    output keep_t rd_keep,
    output logic  rd_last,
    output logic  overflow
);

    localparam int AW = $clog2(DEPTH);

    // One extra wrap bit tells full from empty
    typedef logic [AW:0] ptr_t;

    //////////////////////////////////////////////////////////////////////
    // Storage

    beat_t mem_data [DEPTH];
    keep_t mem_keep [DEPTH];
    logic  mem_last [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Pointers and write control

    // wr_ptr runs ahead through the packet being written,
    // commit_ptr marks the end of the last whole packet
    ptr_t wr_ptr;
    ptr_t commit_ptr;
    ptr_t rd_ptr;

    // Set while the tail of a dropped packet is still arriving
    logic dropping;
    logic wr_en;
    logic beat_fits;
    logic store;

    assign wr_en     = wr_valid & wr_sel_this;
    // Occupancy counts uncommitted beats too
    assign beat_fits = (wr_ptr - rd_ptr) < ptr_t'(DEPTH);
    assign store     = wr_en & ~dropping & beat_fits;

    // Only committed beats are visible to the read side
    assign pkt_avail = (commit_ptr != rd_ptr);

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            dropping   <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (wr_en) begin
                if (dropping) begin
                    if (wr_last) begin
                        dropping <= 1'b0;
                    end
                end else if (!beat_fits) begin
                    // Throw away what was written of this packet
                    wr_ptr   <= commit_ptr;
                    overflow <= 1'b1;
                    dropping <= ~wr_last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
            if (rd_req) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory write and read

    always_ff @(posedge clk_ifc) begin
        if (store) begin
            mem_data[wr_ptr[AW-1:0]] <= wr_data;
            mem_keep[wr_ptr[AW-1:0]] <= wr_keep;
            mem_last[wr_ptr[AW-1:0]] <= wr_last;
        end
    end

    // Beat appears one cycle after the request
    always_ff @(posedge clk_ifc) begin
        if (rd_req) begin
            rd_data <= mem_data[rd_ptr[AW-1:0]];
            rd_keep <= mem_keep[rd_ptr[AW-1:0]];
            rd_last <= mem_last[rd_ptr[AW-1:0]];
        end
    end

endmodule

// File: design/egress_width_serializer.sv
/* Output stage: breaks buffered 64-bit beats into port-width
   words with keep and last, one word per cycle within a packet */

`timescale 1ns/1ns

module egress_width_serializer
    import egress_pkg::*;
#(
    parameter int PORT_BYTES = 1
) (
    input  logic                    clk_ifc,
    input  logic                    rst,
    input  logic                    pkt_avail,
    input  beat_t                   rd_data,
    input  keep_t                   rd_keep,
    input  logic                    rd_last,
    output logic                    rd_req,
    output logic                    out_valid,
    output logic [PORT_BYTES*8-1:0] out_data,
    output logic [PORT_BYTES-1:0]   out_keep,
    output logic                    out_last
);

    localparam int WORDS = BEAT_BYTES / PORT_BYTES;
    localparam int OFF_W = $clog2(WORDS);

    typedef logic [OFF_W-1:0] off_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_SHIFT
    } state_t;

    state_t state;
    beat_t  beat_q;
    keep_t  keep_q;
    logic   last_q;
    off_t   offset;
    off_t   last_word;
    logic   word_end;
    logic   pkt_end;

    // Word holding the highest valid byte of the held beat
    always_comb begin
        last_word = '0;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            if (keep_q[i]) begin
                last_word = off_t'(i / PORT_BYTES);
            end
        end
    end

    assign word_end = (offset == off_t'(WORDS - 1));
    assign pkt_end  = (state == S_SHIFT) && last_q && (offset == last_word);

    // Ask one word early so the next beat lands as this one runs out
    assign rd_req = ((state == S_IDLE) && pkt_avail) ||
                    ((state == S_SHIFT) && !last_q && (offset == off_t'(WORDS - 2))) ||
                    (pkt_end && pkt_avail);

    assign out_valid = (state == S_SHIFT);
    assign out_data  = beat_q[offset*PORT_BYTES*8 +: PORT_BYTES*8];
    assign out_keep  = keep_q[offset*PORT_BYTES +: PORT_BYTES];
    assign out_last  = pkt_end;

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            state  <= S_IDLE;
            offset <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pkt_avail) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state  <= S_SHIFT;
                    offset <= '0;
                end
                S_SHIFT: begin
                    if (pkt_end) begin
                        // Next packet already committed, go fetch it
                        state <= pkt_avail ? S_FETCH : S_IDLE;
                    end else begin
                        // Wraps to zero at the end of a beat
                        offset <= offset + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Take a fresh beat on fetch or when the held one is used up
    always_ff @(posedge clk_ifc) begin
        if ((state == S_FETCH) || ((state == S_SHIFT) && word_end && !last_q)) begin
            beat_q <= rd_data;
            keep_q <= rd_keep;
            last_q <= rd_last;
        end
    end

endmodule

// File: design/mpls_egress.sv
/* MPLS egress stage top level: port decode, one packet buffer
   per port, and width serializers for the narrow and wide ports */

`timescale 1ns/1ns

module mpls_egress
    import egress_pkg::*;
#(
    parameter int NARROW_PORTS = NUM_NARROW_PORTS,
    parameter int WIDE_PORTS   = NUM_WIDE_PORTS,
    parameter int BUFFER_DEPTH = BUFFER_BEATS
) (
    input  logic                                  clk_ifc,
    input  logic                                  rst,
    input  logic                                  in_valid,
    input  beat_t                                 in_data,
    input  keep_t                                 in_keep,
    input  logic                                  in_last,
    input  port_idx_t                             in_port,
    output logic [NARROW_PORTS-1:0]               narrow_valid,
    output logic [NARROW_PORTS-1:0][7:0]          narrow_data,
    output logic [NARROW_PORTS-1:0]               narrow_last,
    output logic [WIDE_PORTS-1:0]                 wide_valid,
    output logic [WIDE_PORTS-1:0][31:0]           wide_data,
    output logic [WIDE_PORTS-1:0][3:0]            wide_keep,
    output logic [WIDE_PORTS-1:0]                 wide_last,
    output logic [NARROW_PORTS+WIDE_PORTS-1:0]    overflow
);

    localparam int PORTS = NARROW_PORTS + WIDE_PORTS;

    logic             wr_valid;
    beat_t            wr_data;
    keep_t            wr_keep;
    logic             wr_last;
    logic [PORTS-1:0] wr_sel;

    logic [PORTS-1:0] pkt_avail;
    logic [PORTS-1:0] rd_req;
    logic [PORTS-1:0] rd_last;
    beat_t            rd_data [PORTS];
    keep_t            rd_keep [PORTS];

    egress_port_decode #(
        .PORTS (PORTS)
    ) i_port_decode (
        .clk_ifc  (clk_ifc),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_keep  (in_keep),
        .in_last  (in_last),
        .in_port  (in_port),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_keep  (wr_keep),
        .wr_last  (wr_last),
        .wr_sel   (wr_sel)
    );

    //////////////////////////////////////////////////////////////////////
    // Packet buffers, indexed by destination port

    for (genvar p = 0; p < PORTS; p++) begin : g_buf
        egress_packet_buffer #(
            .DEPTH (BUFFER_DEPTH)
        ) i_buffer (
            .clk_ifc     (clk_ifc),
            .rst         (rst),
            .wr_valid    (wr_valid),
            .wr_sel_this (wr_sel[p]),
            .wr_data     (wr_data),
            .wr_keep     (wr_keep),
            .wr_last     (wr_last),
            .rd_req      (rd_req[p]),
            .pkt_avail   (pkt_avail[p]),
            .rd_data     (rd_data[p]),
            .rd_keep     (rd_keep[p]),
            .rd_last     (rd_last[p]),
            .overflow    (overflow[p])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Serializers

    // Narrow ports carry no keep
    for (genvar i = 0; i < NARROW_PORTS; i++) begin : g_narrow
        egress_width_serializer #(
            .PORT_BYTES (1)
        ) i_serializer (
            .clk_ifc   (clk_ifc),
            .rst       (rst),
            .pkt_avail (pkt_avail[i]),
            .rd_data   (rd_data[i]),
            .rd_keep   (rd_keep[i]),
            .rd_last   (rd_last[i]),
            .rd_req    (rd_req[i]),
            .out_valid (narrow_valid[i]),
            .out_data  (narrow_data[i]),
            .out_keep  (),
            .out_last  (narrow_last[i])
        );
    end

    // Wide ports sit after the narrow ones in the buffer index
    for (genvar j = 0; j < WIDE_PORTS; j++) begin : g_wide
        egress_width_serializer #(
            .PORT_BYTES (4)
        ) i_serializer (
            .clk_ifc   (clk_ifc),
            .rst       (rst),
            .pkt_avail (pkt_avail[NARROW_PORTS+j]),
            .rd_data   (rd_data[NARROW_PORTS+j]),
            .rd_keep   (rd_keep[NARROW_PORTS+j]),
            .rd_last   (rd_last[NARROW_PORTS+j]),
            .rd_req    (rd_req[NARROW_PORTS+j]),
            .out_valid (wide_valid[j]),
            .out_data  (wide_data[j]),
            .out_keep  (wide_keep[j]),
            .out_last  (wide_last[j])
        );
    end

endmodule

// File: testbench/mpls_egress_checker.sv
/* Protocol assertions on the egress outputs, bound to the top level */

`timescale 1ns/1ns

module mpls_egress_checker
    import egress_pkg::*;
#(
    parameter int NARROW_PORTS = NUM_NARROW_PORTS,
    parameter int WIDE_PORTS   = NUM_WIDE_PORTS
) (
    input logic                               clk_ifc,
    input logic                               rst,
    input logic [NARROW_PORTS-1:0]            narrow_valid,
    input logic [NARROW_PORTS-1:0]            narrow_last,
    input logic [WIDE_PORTS-1:0]              wide_valid,
    input logic [WIDE_PORTS-1:0][3:0]         wide_keep,
    input logic [WIDE_PORTS-1:0]              wide_last,
    input logic [NARROW_PORTS+WIDE_PORTS-1:0] overflow
);

    // Quiet outputs once reset has been applied on at least one edge
    reset_quiet: assert property (@(posedge clk_ifc)
        rst && $past(rst) |-> (narrow_valid == '0) && (wide_valid == '0) && (overflow == '0))
        else $error("valid or overflow output active during reset");

    last_needs_valid: assert property (@(posedge clk_ifc) disable iff (rst)
        ((narrow_last & ~narrow_valid) == '0) && ((wide_last & ~wide_valid) == '0))
        else $error("last output high without its valid");

    for (genvar w = 0; w < WIDE_PORTS; w++) begin : g_keep
        keep_shape: assert property (@(posedge clk_ifc) disable iff (rst)
            wide_valid[w] |-> (wide_keep[w] != 4'h0) && (wide_last[w] || (wide_keep[w] == 4'hf)))
            else $error("wide port %0d keep mask malformed", w);
    end

endmodule

bind mpls_egress mpls_egress_checker #(
    .NARROW_PORTS (NARROW_PORTS),
    .WIDE_PORTS   (WIDE_PORTS)
) i_checker (
    .clk_ifc      (clk_ifc),
    .rst          (rst),
    .narrow_valid (narrow_valid),
    .narrow_last  (narrow_last),
    .wide_valid   (wide_valid),
    .wide_keep    (wide_keep),
    .wide_last    (wide_last),
    .overflow     (overflow)
);

// File: testbench/mpls_egress_tb.sv
/* Testbench for the MPLS egress stage: clock, reset, packet driver,
   per-port reassembly and directed tests */

`timescale 1ns/1ns

module mpls_egress_tb
    import egress_pkg::*;
();

    localparam int SEED_INIT       = 18361;
    localparam int TIMEOUT_CYCLES  = 20000;
    localparam int DEMUX_PACKETS   = 20;
    localparam int RANDOM_PACKETS  = 24;
    localparam int FLOOD_PACKETS   = 10;
    localparam int RECOVER_PACKETS = 8;

    logic                                 clk_ifc;
    logic                                 rst;
    logic                                 in_valid;
    beat_t                                in_data;
    keep_t                                in_keep;
    logic                                 in_last;
    port_idx_t                            in_port;
    logic [NUM_NARROW_PORTS-1:0]          narrow_valid;
    logic [NUM_NARROW_PORTS-1:0][7:0]     narrow_data;
    logic [NUM_NARROW_PORTS-1:0]          narrow_last;
    logic [NUM_WIDE_PORTS-1:0]            wide_valid;
    logic [NUM_WIDE_PORTS-1:0][31:0]      wide_data;
    logic [NUM_WIDE_PORTS-1:0][3:0]       wide_keep;
    logic [NUM_WIDE_PORTS-1:0]            wide_last;
    logic [NUM_PORTS-1:0]                 overflow;

    integer seed;
    int     errors;
    int     packets;
    int     cycle_count;
    int     ovf_count [NUM_PORTS];

    // Expected traffic per port, filled by the driver
    logic [7:0] exp_bytes [NUM_PORTS][$];
    int         exp_len   [NUM_PORTS][$];
    // Reassembled traffic per port
    logic [7:0] rx_bytes  [NUM_PORTS][$];
    int         rx_len    [NUM_PORTS][$];
    int         rx_words  [NUM_PORTS][$];
    logic [3:0] rx_keep   [NUM_PORTS][$];
    logic [7:0] cur_bytes [NUM_PORTS][$];
    int         cur_words [NUM_PORTS];

    mpls_egress #(
        .NARROW_PORTS (NUM_NARROW_PORTS),
        .WIDE_PORTS   (NUM_WIDE_PORTS),
        .BUFFER_DEPTH (BUFFER_BEATS)
    ) i_mpls_egress (
        .clk_ifc      (clk_ifc),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .in_last      (in_last),
        .in_port      (in_port),
        .narrow_valid (narrow_valid),
        .narrow_data  (narrow_data),
        .narrow_last  (narrow_last),
        .wide_valid   (wide_valid),
        .wide_data    (wide_data),
        .wide_keep    (wide_keep),
        .wide_last    (wide_last),
        .overflow     (overflow)
    );

    always #2 clk_ifc = ~clk_ifc;

    task automatic log_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor and per-port reassembly

    task automatic finish_packet(input int p, input logic [3:0] keep);
        rx_len[p].push_back(cur_bytes[p].size());
        while (cur_bytes[p].size() > 0) begin
            rx_bytes[p].push_back(cur_bytes[p].pop_front());
        end
        rx_words[p].push_back(cur_words[p]);
        rx_keep[p].push_back(keep);
        cur_words[p] = 0;
    endtask

    // Sampled on the falling edge where all outputs are stable
    always @(negedge clk_ifc) begin
        int p;
        int b;
        if (!rst) begin
            for (p = 0; p < NUM_PORTS; p++) begin
                if (overflow[p]) begin
                    ovf_count[p]++;
                end
            end
            for (p = 0; p < NUM_NARROW_PORTS; p++) begin
                if (narrow_valid[p]) begin
                    cur_bytes[p].push_back(narrow_data[p]);
                    cur_words[p]++;
                    if (narrow_last[p]) begin
                        finish_packet(p, 4'h1);
                    end
                end
            end
            for (p = 0; p < NUM_WIDE_PORTS; p++) begin
                if (wide_valid[p]) begin
                    for (b = 0; b < 4; b++) begin
                        if (wide_keep[p][b]) begin
                            cur_bytes[NUM_NARROW_PORTS+p].push_back(wide_data[p][b*8 +: 8]);
                        end
                    end
                    cur_words[NUM_NARROW_PORTS+p]++;
                    if (!wide_last[p] && (wide_keep[p] != 4'hf)) begin
                        log_error($sformatf("wide port %0d partial keep %h before last",
                                            p, wide_keep[p]));
                    end
                    if (wide_last[p]) begin
                        finish_packet(NUM_NARROW_PORTS + p, wide_keep[p]);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Driver helpers

    // Payload counts up from a random first byte
    task automatic send_packet(input int port, input int len, input bit record,
                               output logic [7:0] first);
        beat_t data;
        keep_t keep;
        int    nbeats;
        int    b;
        int    k;
        int    idx;
        first  = 8'($random(seed));
        nbeats = (len + BEAT_BYTES - 1) / BEAT_BYTES;
        for (b = 0; b < nbeats; b++) begin
            data = '0;
            keep = '0;
            for (k = 0; k < BEAT_BYTES; k++) begin
                idx = b * BEAT_BYTES + k;
                if (idx < len) begin
                    data[k*8 +: 8] = 8'(first + idx);
                    keep[k]        = 1'b1;
                end
            end
            @(posedge clk_ifc);
            #1;
            in_valid = 1'b1;
            in_data  = data;
            in_keep  = keep;
            in_last  = (b == nbeats - 1);
            in_port  = port_idx_t'(port);
        end
        if (record) begin
            for (idx = 0; idx < len; idx++) begin
                exp_bytes[port].push_back(8'(first + idx));
            end
            exp_len[port].push_back(len);
        end
    endtask

    task automatic bus_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_ifc);
            #1;
            in_valid = 1'b0;
            in_last  = 1'b0;
            in_keep  = '0;
            in_data  = '0;
        end
    endtask

    function automatic int rx_total();
        int p;
        int sum;
        sum = 0;
        for (p = 0; p < NUM_PORTS; p++) begin
            sum += rx_len[p].size();
        end
        return sum;
    endfunction

    function automatic int ovf_total();
        int p;
        int sum;
        sum = 0;
        for (p = 0; p < NUM_PORTS; p++) begin
            sum += ovf_count[p];
        end
        return sum;
    endfunction

    task automatic wait_total(input int n);
        while (rx_total() < n) begin
            @(posedge clk_ifc);
        end
    endtask

    // Pops every port's queues and matches received against expected
    task automatic compare_ports(input string test);
        int         p;
        int         i;
        int         el;
        int         rl;
        int         rw;
        int         rem;
        int         mism;
        logic [7:0] e;
        logic [7:0] r;
        logic [3:0] rk;
        for (p = 0; p < NUM_PORTS; p++) begin
            if (rx_len[p].size() != exp_len[p].size()) begin
                log_error($sformatf("%s: port %0d got %0d packets, expected %0d", test, p,
                                    rx_len[p].size(), exp_len[p].size()));
            end
            while ((exp_len[p].size() > 0) && (rx_len[p].size() > 0)) begin
                el   = exp_len[p].pop_front();
                rl   = rx_len[p].pop_front();
                rw   = rx_words[p].pop_front();
                rk   = rx_keep[p].pop_front();
                mism = 0;
                for (i = 0; (i < el) || (i < rl); i++) begin
                    e = 8'h00;
                    r = 8'h00;
                    if (i < el) e = exp_bytes[p].pop_front();
                    if (i < rl) r = rx_bytes[p].pop_front();
                    if (e != r) mism++;
                end
                if (rl != el) begin
                    log_error($sformatf("%s: port %0d length %0d, expected %0d", test, p, rl, el));
                end
                if (mism != 0) begin
                    log_error($sformatf("%s: port %0d %0d bytes differ", test, p, mism));
                end
                if (p >= NUM_NARROW_PORTS) begin
                    rem = (el % 4 == 0) ? 4 : el % 4;
                    if (rw != (el + 3) / 4) begin
                        log_error($sformatf("%s: port %0d %0d words for %0d bytes",
                                            test, p, rw, el));
                    end
                    if (rk != 4'((1 << rem) - 1)) begin
                        log_error($sformatf("%s: port %0d last keep %h for %0d bytes",
                                            test, p, rk, el));
                    end
                end
                packets++;
            end
            exp_len[p].delete();
            exp_bytes[p].delete();
            rx_len[p].delete();
            rx_bytes[p].delete();
            rx_words[p].delete();
            rx_keep[p].delete();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic demux_round_robin();
        logic [7:0] first;
        int         i;
        for (i = 0; i < DEMUX_PACKETS; i++) begin
            send_packet(i % NUM_PORTS, 1 + (i * 7) % MAX_PACKET_BYTES, 1'b1, first);
            bus_idle(1);
            wait_total(i + 1);
        end
        compare_ports("demux");
    endtask

    task automatic random_lengths();
        logic [7:0] first;
        int         i;
        int         len;
        int         port;
        for (i = 0; i < RANDOM_PACKETS; i++) begin
            // The first four lengths are 3, 23, 43 and 63
            len  = (i < 4) ? 3 + 20 * i : 1 + $unsigned($random(seed)) % MAX_PACKET_BYTES;
            port = $unsigned($random(seed)) % NUM_PORTS;
            send_packet(port, len, 1'b1, first);
            bus_idle(1);
            wait_total(i + 1);
        end
        compare_ports("lengths");
    endtask

    task automatic back_to_back_ports();
        logic [7:0] first;
        int         p;
        int         base;
        base = ovf_total();
        for (p = 0; p < NUM_PORTS; p++) begin
            send_packet(p, MAX_PACKET_BYTES, 1'b1, first);
        end
        bus_idle(1);
        wait_total(NUM_PORTS);
        compare_ports("back-to-back");
        if (ovf_total() != base) begin
            log_error("back-to-back: unexpected overflow strobe");
        end
    endtask

    task automatic overflow_drop();
        logic [7:0] first;
        logic [7:0] starts [$];
        logic [7:0] b0;
        logic [7:0] b;
        int         base [NUM_PORTS];
        int         p;
        int         i;
        int         k;
        int         got;
        int         len;
        int         pos;
        int         found;
        int         mism;
        for (p = 0; p < NUM_PORTS; p++) begin
            base[p] = ovf_count[p];
        end
        for (i = 0; i < FLOOD_PACKETS; i++) begin
            send_packet(0, MAX_PACKET_BYTES, 1'b0, first);
            starts.push_back(first);
        end
        bus_idle(1);
        // Every packet ends up either delivered or dropped
        while (rx_len[0].size() + ovf_count[0] - base[0] < FLOOD_PACKETS) begin
            @(posedge clk_ifc);
        end
        if (ovf_count[0] == base[0]) begin
            log_error("overflow: no overflow strobe on port 0");
        end
        for (p = 1; p < NUM_PORTS; p++) begin
            if (ovf_count[p] != base[p]) begin
                log_error($sformatf("overflow: strobe on port %0d", p));
            end
        end
        got = rx_len[0].size();
        if ((got < 4) || (got >= FLOOD_PACKETS)) begin
            log_error($sformatf("overflow: port 0 delivered %0d packets", got));
        end
        pos = 0;
        for (i = 0; i < got; i++) begin
            len   = rx_len[0].pop_front();
            b0    = 8'h00;
            mism  = 0;
            for (k = 0; k < len; k++) begin
                b = rx_bytes[0].pop_front();
                if (k == 0) b0 = b;
                else if (b != 8'(b0 + k)) mism++;
            end
            found = 0;
            for (k = pos; (k < FLOOD_PACKETS) && (found == 0); k++) begin
                if (starts[k] == b0) begin
                    found = 1;
                    pos   = k + 1;
                end
            end
            if ((len != MAX_PACKET_BYTES) || (mism != 0) || (found == 0)) begin
                log_error($sformatf("overflow: packet %0d damaged or out of order", i));
            end
            packets++;
        end
        compare_ports("overflow");
    endtask

    task automatic idle_recovery();
        logic [7:0] first;
        int         i;
        int         base;
        base = ovf_total();
        bus_idle(700);
        for (i = 0; i < RECOVER_PACKETS; i++) begin
            send_packet(i % NUM_PORTS, 1 + $unsigned($random(seed)) % MAX_PACKET_BYTES,
                        1'b1, first);
            bus_idle(30);
        end
        wait_total(RECOVER_PACKETS);
        compare_ports("recovery");
        if (ovf_total() != base) begin
            log_error("recovery: unexpected overflow strobe");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run control

    always @(posedge clk_ifc) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed        = SEED_INIT;
        errors      = 0;
        packets     = 0;
        cycle_count = 0;
        clk_ifc     = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        in_port     = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            ovf_count[p] = 0;
            cur_words[p] = 0;
        end
        repeat (5) @(posedge clk_ifc);
        #1;
        rst = 1'b0;
        demux_round_robin();
        random_lengths();
        back_to_back_ports();
        overflow_drop();
        idle_recovery();
        $display("Packets checked: %0d, errors: %0d", packets, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/egress_pkg.sv
design/egress_port_decode.sv
design/egress_packet_buffer.sv
design/egress_width_serializer.sv
design/mpls_egress.sv
testbench/mpls_egress_checker.sv
testbench/mpls_egress_tb.sv

// File: Makefile
TOP := mpls_egress_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

# Passes only when the pass line appears in the simulation output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir
